// ==== eth_xover_x8.f ====
+incdir+verification
hw/eth_bus_pkg.sv
hw/frame_buf_pkg.sv
hw/frame_rd_if.sv
hw/byte_out_if.sv
hw/frame_admit.sv
hw/frame_len_fifo.sv
hw/frame_data_buf.sv
hw/xover_pop_ctrl.sv
hw/byte_serializer.sv
hw/eth_xover_x8.sv
verification/tb_eth_xover_x8.sv

// ==== Bender.yml ====
package:
  name: eth_xover_x8

sources:
  - hw/eth_bus_pkg.sv
  - hw/frame_buf_pkg.sv
  - hw/frame_rd_if.sv
  - hw/byte_out_if.sv
  - hw/frame_admit.sv
  - hw/frame_len_fifo.sv
  - hw/frame_data_buf.sv
  - hw/xover_pop_ctrl.sv
  - hw/byte_serializer.sv
  - hw/eth_xover_x8.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_eth_xover_x8.sv

// ==== verification/xover_model.svh ====
`ifndef XOVER_MODEL_SVH
`define XOVER_MODEL_SVH

typedef eth_byte_t byte_q_t[$];
typedef eth_word_t word_q_t[$];

//////////////////////////////////////////////////
// Model state

int unsigned lcg_state = 52996;
int          held_words[$];  // Words of each committed frame not yet released
eth_byte_t   exp_bytes[$];   // Expected output bytes, all frames in commit order
frame_len_t  exp_lens[$];    // Expected frame lengths in commit order
int          errors;
int          checks;

// Linear congruential generator, 32 bit state
function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

// Frame length 1 to MAX_FRAME_BYTES from the upper state bits
function automatic frame_len_t random_len();
	logic [31:0] r;
	r = lcg_next();
	return frame_len_t'(1 + (int'(r[30:16]) % MAX_FRAME_BYTES));
endfunction

// Bytes of a frame as the wire should carry them
// Top octet of each word first, cut to the frame length
function automatic byte_q_t frame_bytes(word_q_t words, frame_len_t len);
	byte_q_t   bytes;
	eth_word_t w;
	for (int i = 0; i < int'(len); i++) begin
		w = words[i / 4];
		bytes.push_back(w[31 - 8 * (i % 4) -: 8]);
	end
	return bytes;
endfunction

// Admission rule at rx_start
// Room for a maximum sized frame and a free length slot
function automatic bit admit_predicted();
	int used;
	used = 0;
	foreach (held_words[i])
		used += held_words[i];
	return ((DATA_DEPTH - used) >= RESERVE_WORDS) && (held_words.size() < LEN_DEPTH);
endfunction

//////////////////////////////////////////////////
// Compares

task automatic byte_compare(input string name, input eth_byte_t got, input eth_byte_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("ERR t=%0t %s exp=%02h got=%02h", $time, name, exp, got);
	end
endtask

task automatic len_compare(input string name, input frame_len_t got, input frame_len_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("ERR t=%0t %s exp=%0d got=%0d", $time, name, exp, got);
	end
endtask

task automatic bit_compare(input string name, input logic got, input logic exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("ERR t=%0t %s exp=%b got=%b", $time, name, exp, got);
	end
endtask

// Anything that is not a wrong value
task automatic note_failure(input string what);
	errors++;
	$display("t=%0t %s", $time, what);
endtask

`endif

// ==== verification/tb_eth_xover_x8.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_eth_xover_x8
	import eth_bus_pkg::*;
();
	localparam int DATA_DEPTH      = 64;
	localparam int LEN_DEPTH       = 4;
	localparam int MAX_FRAME_BYTES = 64;
	localparam int RESERVE_WORDS   = (MAX_FRAME_BYTES + 3) / 4;

	// Frames per test
	localparam int SINGLE_FRAMES = 6;
	localparam int STREAM_FRAMES = 20;
	localparam int DROP_PAIRS    = 4;
	localparam int FILL_FRAMES   = 7;
	localparam int TOTAL_FRAMES  = SINGLE_FRAMES + STREAM_FRAMES + 2 * DROP_PAIRS
		+ FILL_FRAMES + LEN_DEPTH + 1;

	// Four cycles per byte at most, plus slack for reset and gaps
	localparam int WATCHDOG_CYCLES = TOTAL_FRAMES * MAX_FRAME_BYTES * 4 + 2000;
	localparam int DRAIN_LIMIT     = 1500;

	logic       rx_clk;
	logic       rx_rst;
	logic       rx_start;
	logic       rx_data_valid;
	eth_lanes_t rx_bytes_valid;
	eth_word_t  rx_data;
	logic       rx_commit;
	logic       rx_drop;
	logic       tx_ready;
	logic       tx_start;
	logic       tx_data_valid;
	eth_byte_t  tx_data;
	logic       frame_dropped;

	bit         ready_random;  // tx_ready gets a new random bit each cycle
	bit         in_frame;      // Monitor is between tx_start and the last byte
	frame_len_t cur_len;
	frame_len_t got_len;
	logic       rdy_d1;
	logic       rdy_d2;
	int         frames_out;
	int         refused;

	`include "xover_model.svh"

	eth_xover_x8 #(
		.DATA_DEPTH      (DATA_DEPTH),
		.LEN_DEPTH       (LEN_DEPTH),
		.MAX_FRAME_BYTES (MAX_FRAME_BYTES)
	) i_eth_xover_x8 (
		.rx_clk         (rx_clk),
		.rx_rst         (rx_rst),
		.rx_start       (rx_start),
		.rx_data_valid  (rx_data_valid),
		.rx_bytes_valid (rx_bytes_valid),
		.rx_data        (rx_data),
		.rx_commit      (rx_commit),
		.rx_drop        (rx_drop),
		.tx_ready       (tx_ready),
		.tx_start       (tx_start),
		.tx_data_valid  (tx_data_valid),
		.tx_data        (tx_data),
		.frame_dropped  (frame_dropped)
	);

	initial begin : clock_gen
		rx_clk = 1'b0;
		forever #50 rx_clk = ~rx_clk;
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge rx_clk);
		$display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

	//////////////////////////////////////////////////
	// Stimulus helpers

	// Inputs change on the falling edge only
	task automatic next_cycle();
		logic [31:0] r;
		@(negedge rx_clk);
		if (ready_random) begin
			r        = lcg_next();
			tx_ready = r[31];
		end
	endtask

	// One whole frame on the receive bus, ended by commit or drop
	task automatic send_frame(input frame_len_t len, input bit drop_it);
		word_q_t words;
		byte_q_t bytes;
		int      nwords;
		int      left;
		bit      refuse;
		nwords = (int'(len) + 3) / 4;
		for (int i = 0; i < nwords; i++)
			words.push_back(lcg_next());
		refuse = !admit_predicted();
		next_cycle();
		rx_start = 1'b1;
		next_cycle();
		rx_start = 1'b0;
		// Admit decision shows one cycle after rx_start
		bit_compare("frame_dropped", frame_dropped, refuse);
		if (frame_dropped === 1'b1)
			refused++;
		left = int'(len);
		for (int i = 0; i < nwords; i++) begin
			rx_data_valid  = 1'b1;
			rx_data        = words[i];
			rx_bytes_valid = eth_lanes_t'((left > 4) ? 4 : left);
			left           = left - 4;
			next_cycle();
		end
		rx_data_valid = 1'b0;
		if (drop_it)
			rx_drop = 1'b1;
		else
			rx_commit = 1'b1;
		if (!refuse && !drop_it) begin
			bytes = frame_bytes(words, len);
			foreach (bytes[i])
				exp_bytes.push_back(bytes[i]);
			exp_lens.push_back(len);
			held_words.push_back(nwords);
		end
		next_cycle();
		rx_commit = 1'b0;
		rx_drop   = 1'b0;
	endtask

	// Until the model admits the next frame
	task automatic wait_room();
		int n;
		n = 0;
		while (!admit_predicted() && n < DRAIN_LIMIT) begin
			next_cycle();
			n++;
		end
		if (!admit_predicted())
			note_failure("buffer space never came back for the next frame");
	endtask

	// Until every committed frame has left the DUT
	task automatic wait_drained();
		int n;
		n = 0;
		while ((exp_lens.size() != 0 || in_frame) && n < DRAIN_LIMIT) begin
			next_cycle();
			n++;
		end
		if (exp_lens.size() != 0 || in_frame)
			note_failure("committed frames still missing at the output after the drain limit");
	endtask

	task automatic test_done(input string name, input int err_before);
		if (errors == err_before)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - err_before);
	endtask

	//////////////////////////////////////////////////
	// Output monitor

	// Outputs read on the rising edge, before the DUT flops update
	initial begin : monitor
		eth_byte_t exp_b;
		in_frame = 1'b0;
		cur_len  = '0;
		got_len  = '0;
		rdy_d1   = 1'b0;
		rdy_d2   = 1'b0;
		forever begin
			@(posedge rx_clk);
			if (rx_rst) begin
				in_frame = 1'b0;
				got_len  = '0;
				rdy_d1   = 1'b0;
				rdy_d2   = 1'b0;
			end else begin
				if (tx_start) begin
					// IDLE took tx_ready two edges back
					bit_compare("tx_ready before tx_start", rdy_d2, 1'b1);
					if (in_frame) begin
						len_compare("tx_data_valid count", got_len, cur_len);
						// Skip what is left of the short frame
						while (got_len < cur_len && exp_bytes.size() != 0) begin
							exp_b   = exp_bytes.pop_front();
							got_len = got_len + 11'd1;
						end
					end
					if (exp_lens.size() == 0) begin
						in_frame = 1'b0;
						note_failure("tx_start with no committed frame waiting");
					end else begin
						cur_len  = exp_lens.pop_front();
						got_len  = '0;
						in_frame = 1'b1;
					end
				end
				if (tx_data_valid) begin
					if (!in_frame || exp_bytes.size() == 0) begin
						note_failure("tx_data_valid outside a frame");
					end else begin
						exp_b = exp_bytes.pop_front();
						byte_compare("tx_data", tx_data, exp_b);
						got_len = got_len + 11'd1;
						// Last byte, the frame's words are freed on this edge
						if (got_len == cur_len) begin
							in_frame = 1'b0;
							frames_out++;
							if (held_words.size() != 0)
								held_words.delete(0);
						end
					end
				end
				rdy_d2 = rdy_d1;
				rdy_d1 = tx_ready;
			end
		end
	end

	//////////////////////////////////////////////////
	// Test sequence

	initial begin : main
		int err_mark;
		int refused_mark;
		rx_rst         = 1'b1;
		rx_start       = 1'b0;
		rx_data_valid  = 1'b0;
		rx_bytes_valid = '0;
		rx_data        = '0;
		rx_commit      = 1'b0;
		rx_drop        = 1'b0;
		tx_ready       = 1'b0;
		ready_random   = 1'b0;
		repeat (16) next_cycle();
		rx_rst   = 1'b0;
		tx_ready = 1'b1;

		// Single frames, shortest and longest first
		err_mark = errors;
		for (int i = 0; i < SINGLE_FRAMES; i++) begin
			if (i == 0)
				send_frame(frame_len_t'(1), 1'b0);
			else if (i == 1)
				send_frame(frame_len_t'(MAX_FRAME_BYTES), 1'b0);
			else
				send_frame(random_len(), 1'b0);
			wait_drained();
		end
		test_done("test 1 single frames", err_mark);

		// Back to back with tx_ready at random
		err_mark     = errors;
		ready_random = 1'b1;
		for (int i = 0; i < STREAM_FRAMES; i++) begin
			wait_room();
			send_frame(random_len(), 1'b0);
		end
		ready_random = 1'b0;
		tx_ready     = 1'b1;
		wait_drained();
		test_done("test 2 stream with random tx_ready", err_mark);

		// Dropped frames each followed by a good one
		err_mark = errors;
		for (int i = 0; i < DROP_PAIRS; i++) begin
			wait_room();
			send_frame(random_len(), 1'b1);
			wait_room();
			send_frame(random_len(), 1'b0);
		end
		wait_drained();
		test_done("test 3 dropped frames", err_mark);

		// Output held, buffer fills until frames are refused
		err_mark     = errors;
		refused_mark = refused;
		tx_ready     = 1'b0;
		for (int i = 0; i < FILL_FRAMES; i++)
			send_frame(random_len(), 1'b0);
		if (refused == refused_mark)
			note_failure("no frame was refused while the output was held");
		tx_ready = 1'b1;
		wait_drained();
		test_done("test 4 refusal when full", err_mark);

		// Reset as a held frame is taken and a new frame starts
		err_mark = errors;
		tx_ready = 1'b0;
		for (int i = 0; i < LEN_DEPTH; i++)
			send_frame(random_len(), 1'b0);
		// IDLE sees tx_ready in this cycle and moves to LEN_TAKE
		tx_ready = 1'b1;
		next_cycle();
		// Length FIFO still full, so this start would be refused
		rx_rst   = 1'b1;
		rx_start = 1'b1;
		next_cycle();
		rx_start = 1'b0;
		// Everything held in the DUT is gone
		exp_bytes.delete();
		exp_lens.delete();
		held_words.delete();
		// Without the reset tx_start, frame_dropped and tx_data_valid rise in here
		repeat (4) begin
			bit_compare("tx_start", tx_start, 1'b0);
			bit_compare("tx_data_valid", tx_data_valid, 1'b0);
			bit_compare("frame_dropped", frame_dropped, 1'b0);
			rx_data_valid  = 1'b1;
			rx_bytes_valid = eth_lanes_t'(4);
			rx_data        = lcg_next();
			next_cycle();
		end
		rx_data_valid = 1'b0;
		rx_rst        = 1'b0;
		// Tail of the cut frame and its commit are ignored
		repeat (2) begin
			rx_data_valid  = 1'b1;
			rx_bytes_valid = eth_lanes_t'(4);
			rx_data        = lcg_next();
			next_cycle();
		end
		rx_data_valid = 1'b0;
		rx_commit     = 1'b1;
		next_cycle();
		rx_commit = 1'b0;
		// Any tx_start here is flagged by the monitor
		repeat (30) next_cycle();
		send_frame(random_len(), 1'b0);
		wait_drained();
		test_done("test 5 reset in mid frame", err_mark);

		$display("checks %0d, errors %0d, frames out %0d, frames refused %0d",
			checks, errors, frames_out, refused);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/eth_xover_x8.sv ====
`timescale 1ns/100ps
`default_nettype none

// Ethernet crossover
// Receive words in, whole frames buffered, transmit bytes out
module eth_xover_x8
	import eth_bus_pkg::*;
#(
	parameter int DATA_DEPTH      = 1024,
	parameter int LEN_DEPTH       = 64,
	parameter int MAX_FRAME_BYTES = 1500
) (
	input wire              rx_clk,
	input wire              rx_rst,
	input wire              rx_start,
	input wire              rx_data_valid,
	input wire eth_lanes_t  rx_bytes_valid,
	input wire eth_word_t   rx_data,
	input wire              rx_commit,
	input wire              rx_drop,
	input wire              tx_ready,
	output logic            tx_start,
	output logic            tx_data_valid,
	output eth_byte_t       tx_data,
	output logic            frame_dropped
);
	localparam int ADDR_W = $clog2(DATA_DEPTH);

	//////////////////////////////////////////////////
	// Write side

	logic            wr_en;
	logic            commit;
	logic            rollback;
	frame_len_t      push_len;
	logic [ADDR_W:0] free_words;
	logic            len_full;
	logic            len_pop;
	frame_len_t      head_len;
	logic            len_empty;

	frame_rd_if #(.DATA_DEPTH(DATA_DEPTH)) rd_bus ();
	byte_out_if ser_bus ();

	frame_admit #(
		.DATA_DEPTH      (DATA_DEPTH),
		.MAX_FRAME_BYTES (MAX_FRAME_BYTES)
	) i_frame_admit (
		.rx_clk         (rx_clk),
		.rx_rst         (rx_rst),
		.rx_start       (rx_start),
		.rx_data_valid  (rx_data_valid),
		.rx_bytes_valid (rx_bytes_valid),
		.rx_commit      (rx_commit),
		.rx_drop        (rx_drop),
		.free_words     (free_words),
		.len_full       (len_full),
		.wr_en          (wr_en),
		.commit         (commit),
		.rollback       (rollback),
		.push_len       (push_len),
		.frame_dropped  (frame_dropped)
	);

	// Commit doubles as the length push
	frame_len_fifo #(.LEN_DEPTH(LEN_DEPTH)) i_frame_len_fifo (
		.rx_clk   (rx_clk),
		.rx_rst   (rx_rst),
		.push     (commit),
		.push_len (push_len),
		.full     (len_full),
		.pop      (len_pop),
		.head_len (head_len),
		.empty    (len_empty)
	);

	frame_data_buf #(.DATA_DEPTH(DATA_DEPTH)) i_frame_data_buf (
		.rx_clk     (rx_clk),
		.rx_rst     (rx_rst),
		.wr_en      (wr_en),
		.wr_data    (rx_data),
		.commit     (commit),
		.rollback   (rollback),
		.free_words (free_words),
		.rd         (rd_bus.target)
	);

	//////////////////////////////////////////////////
	// Read side

	xover_pop_ctrl #(.DATA_DEPTH(DATA_DEPTH)) i_xover_pop_ctrl (
		.rx_clk    (rx_clk),
		.rx_rst    (rx_rst),
		.tx_ready  (tx_ready),
		.len_empty (len_empty),
		.head_len  (head_len),
		.len_pop   (len_pop),
		.rd        (rd_bus.ctrl),
		.ser       (ser_bus.ctrl)
	);

	byte_serializer i_byte_serializer (
		.rx_clk        (rx_clk),
		.rx_rst        (rx_rst),
		.ser           (ser_bus.target),
		.word          (rd_bus.rd_data),
		.tx_start      (tx_start),
		.tx_data_valid (tx_data_valid),
		.tx_data       (tx_data)
	);

endmodule

`default_nettype wire

// ==== hw/byte_serializer.sv ====
`timescale 1ns/100ps
`default_nettype none

// Splits buffered words into transmit bytes
// All transmit outputs leave from flops
module byte_serializer
	import eth_bus_pkg::*;
(
	input wire              rx_clk,
	input wire              rx_rst,
	byte_out_if.target      ser,
	input wire eth_word_t   word,
	output logic            tx_start,
	output logic            tx_data_valid,
	output eth_byte_t       tx_data
);
	eth_word_t held_word;
	eth_byte_t sel_byte;

	// MSB first on the wire
	always_comb begin
		case (ser.lane)
			2'd0:    sel_byte = held_word[31:24];
			2'd1:    sel_byte = held_word[23:16];
			2'd2:    sel_byte = held_word[15:8];
			default: sel_byte = held_word[7:0];
		endcase
	end

	// Data path
	always_ff @(posedge rx_clk) begin
		if (ser.load)
			held_word <= word;
		if (ser.byte_en)
			tx_data <= sel_byte;
	end

	// Strobes
	always_ff @(posedge rx_clk) begin
		if (rx_rst) begin
			tx_start      <= 1'b0;
			tx_data_valid <= 1'b0;
		end else begin
			tx_start      <= ser.frame_start;
			tx_data_valid <= ser.byte_en;
		end
	end

endmodule

`default_nettype wire

// ==== hw/xover_pop_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

// Readout control
// Takes one committed frame at a time and walks it out byte by byte
module xover_pop_ctrl
	import eth_bus_pkg::*;
	import frame_buf_pkg::*;
#(
	parameter int DATA_DEPTH = 1024
) (
	input wire              rx_clk,
	input wire              rx_rst,
	input wire              tx_ready,
	input wire              len_empty,
	input wire frame_len_t  head_len,
	output logic            len_pop,
	frame_rd_if.ctrl        rd,
	byte_out_if.ctrl        ser
);
	localparam int ADDR_W = $clog2(DATA_DEPTH);

	pop_state_t        state;
	frame_len_t        frame_len;
	frame_len_t        bytes_left;   // Including the byte going out now
	lane_idx_t         lane_cnt;
	logic [ADDR_W-1:0] word_offset;  // Next word to fetch
	logic [11:0]       len_round;
	logic              last_byte;
	logic              fetch_next;

	assign last_byte = (bytes_left == 11'd1);

	// Next word is fetched at lane 2 so it is back by lane 3
	assign fetch_next = (state == BYTE_OUT) && (lane_cnt == 2'd2) && (bytes_left > 11'd2);

	// Frame size rounded up to whole words
	assign len_round = {1'b0, frame_len} + 12'd3;

	assign rd.rd_offset     = word_offset;
	assign rd.release_words = (ADDR_W + 1)'(len_round[11:2]);
	assign ser.lane         = lane_cnt;

	//////////////////////////////////////////////////
	// Strobes decoded from the state

	always_comb begin
		len_pop         = 1'b0;
		rd.rd_en        = 1'b0;
		rd.release_en   = 1'b0;
		ser.frame_start = 1'b0;
		ser.load        = 1'b0;
		ser.byte_en     = 1'b0;
		case (state)
			LEN_TAKE: begin
				len_pop         = 1'b1;
				rd.rd_en        = 1'b1;
				ser.frame_start = 1'b1;
			end
			WORD_WAIT: begin
				ser.load = 1'b1;
			end
			BYTE_OUT: begin
				ser.byte_en = 1'b1;
				rd.rd_en    = fetch_next;
				// Lane 3 still leaves from the old word while the new one loads
				ser.load    = (lane_cnt == 2'd3) && !last_byte;
			end
			RELEASE: begin
				rd.release_en = 1'b1;
			end
			default: begin
			end
		endcase
	end

	//////////////////////////////////////////////////
	// State and counters

	always_ff @(posedge rx_clk) begin
		if (rx_rst) begin
			state       <= IDLE;
			frame_len   <= '0;
			bytes_left  <= '0;
			lane_cnt    <= '0;
			word_offset <= '0;
		end else begin
			if (rd.rd_en)
				word_offset <= word_offset + ADDR_W'(1);
			case (state)
				// tx_ready only matters here
				IDLE: begin
					word_offset <= '0;
					if (!len_empty && tx_ready)
						state <= LEN_TAKE;
				end
				// Head length is still valid while the pop is in progress
				LEN_TAKE: begin
					frame_len  <= head_len;
					bytes_left <= head_len;
					lane_cnt   <= '0;
					state      <= WORD_WAIT;
				end
				WORD_WAIT: begin
					state <= BYTE_OUT;
				end
				BYTE_OUT: begin
					lane_cnt   <= lane_cnt + 2'd1;
					bytes_left <= bytes_left - 11'd1;
					if (last_byte)
						state <= RELEASE;
				end
				RELEASE: begin
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/frame_data_buf.sv ====
`timescale 1ns/100ps
`default_nettype none

// Frame word buffer
// Writes are speculative until commit and can be rolled back
// Reads address the oldest frame by offset and free it whole
module frame_data_buf
	import eth_bus_pkg::*;
#(
	parameter int DATA_DEPTH = 1024
) (
	input wire                         rx_clk,
	input wire                         rx_rst,
	input wire                         wr_en,
	input wire eth_word_t              wr_data,
	input wire                         commit,
	input wire                         rollback,
	output logic [$clog2(DATA_DEPTH):0] free_words,
	frame_rd_if.target                 rd
);
	localparam int ADDR_W = $clog2(DATA_DEPTH);

	// Pointers carry one extra bit so a full buffer differs from an empty one
	logic [ADDR_W:0]   wr_ptr;      // Speculative write position
	logic [ADDR_W:0]   commit_ptr;  // End of the last committed frame
	logic [ADDR_W:0]   rd_base;     // Start of the oldest frame
	logic [ADDR_W:0]   used_words;
	logic [ADDR_W-1:0] rd_addr;

	eth_word_t mem [DATA_DEPTH];

	//////////////////////////////////////////////////
	// Space accounting

	// Words in flight count as used until rolled back
	assign used_words = wr_ptr - rd_base;
	assign free_words = (ADDR_W + 1)'(DATA_DEPTH) - used_words;

	always_ff @(posedge rx_clk) begin
		if (rx_rst) begin
			wr_ptr     <= '0;
			commit_ptr <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + (ADDR_W + 1)'(1);
			else if (rollback)
				wr_ptr <= commit_ptr;
			if (commit)
				commit_ptr <= wr_ptr;
		end
	end

	always_ff @(posedge rx_clk) begin
		if (rx_rst)
			rd_base <= '0;
		else if (rd.release_en)
			rd_base <= rd_base + rd.release_words;
	end

	//////////////////////////////////////////////////
	// Storage

	// Offset from the oldest frame, wraps with the ring
	assign rd_addr = rd_base[ADDR_W-1:0] + rd.rd_offset;

	always_ff @(posedge rx_clk) begin
		if (wr_en)
			mem[wr_ptr[ADDR_W-1:0]] <= wr_data;
	end

	// One cycle read latency
	always_ff @(posedge rx_clk) begin
		if (rd.rd_en)
			rd.rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// ==== hw/frame_len_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

// Lengths of committed frames in commit order
// Head entry is visible without a read strobe
module frame_len_fifo
	import eth_bus_pkg::*;
#(
	parameter int LEN_DEPTH = 64
) (
	input wire              rx_clk,
	input wire              rx_rst,
	input wire              push,
	input wire frame_len_t  push_len,
	output logic            full,
	input wire              pop,
	output frame_len_t      head_len,
	output logic            empty
);
	localparam int PTR_W = $clog2(LEN_DEPTH);

	frame_len_t       len_mem [LEN_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             do_push;
	logic             do_pop;

	assign do_push  = push && !full;
	assign do_pop   = pop && !empty;
	assign full     = (count == (PTR_W + 1)'(LEN_DEPTH));
	assign empty    = (count == '0);
	assign head_len = len_mem[rd_ptr];

	always_ff @(posedge rx_clk) begin
		if (do_push)
			len_mem[wr_ptr] <= push_len;
	end

	always_ff @(posedge rx_clk) begin
		if (rx_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + PTR_W'(1);
			if (do_pop)
				rd_ptr <= rd_ptr + PTR_W'(1);
			// Occupancy holds when push and pop meet
			case ({do_push, do_pop})
				2'b10:   count <= count + (PTR_W + 1)'(1);
				2'b01:   count <= count - (PTR_W + 1)'(1);
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/frame_admit.sv ====
`timescale 1ns/100ps
`default_nettype none

// Write side admission
// Each frame is checked at rx_start against room for a maximum sized frame
module frame_admit
	import eth_bus_pkg::*;
#(
	parameter int DATA_DEPTH      = 1024,
	parameter int MAX_FRAME_BYTES = 1500
) (
	input wire                         rx_clk,
	input wire                         rx_rst,
	input wire                         rx_start,
	input wire                         rx_data_valid,
	input wire eth_lanes_t             rx_bytes_valid,
	input wire                         rx_commit,
	input wire                         rx_drop,
	input wire [$clog2(DATA_DEPTH):0]  free_words,
	input wire                         len_full,
	output logic                       wr_en,
	output logic                       commit,
	output logic                       rollback,
	output frame_len_t                 push_len,
	output logic                       frame_dropped
);
	localparam int ADDR_W        = $clog2(DATA_DEPTH);
	// Reserve in whole words
	localparam int RESERVE_WORDS = (MAX_FRAME_BYTES + 3) / 4;

	logic       dropping;
	logic       refuse;
	frame_len_t frame_len;

	// Too little room or no free length slot
	assign refuse = (free_words < (ADDR_W + 1)'(RESERVE_WORDS)) || len_full;

	// A refused frame never reaches the buffers
	assign wr_en    = rx_data_valid && !dropping;
	assign commit   = rx_commit && !dropping;
	assign rollback = rx_drop && !dropping;

	// Length goes into the FIFO with the commit strobe
	assign push_len = frame_len;

	always_ff @(posedge rx_clk) begin
		if (rx_rst) begin
			// Words left over from a frame cut by reset are discarded
			dropping      <= 1'b1;
			frame_dropped <= 1'b0;
			frame_len     <= '0;
		end else begin
			frame_dropped <= rx_start && refuse;
			if (rx_start) begin
				dropping  <= refuse;
				frame_len <= '0;
			end else if (rx_data_valid) begin
				frame_len <= frame_len + frame_len_t'(rx_bytes_valid);
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/byte_out_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// Lane control from the pop controller to the byte serializer
interface byte_out_if
	import frame_buf_pkg::*;
();
	logic      frame_start;  // One pulse per frame
	logic      load;         // Take the word on rd_data
	lane_idx_t lane;         // Byte picked from the held word
	logic      byte_en;      // Picked byte goes out

	modport ctrl (output frame_start, load, lane, byte_en);
	modport target (input frame_start, load, lane, byte_en);

endinterface

`default_nettype wire

// ==== hw/frame_rd_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// Read port of the frame data buffer
interface frame_rd_if
	import eth_bus_pkg::*;
#(
	parameter int DATA_DEPTH = 1024
);
	logic                          rd_en;
	logic [$clog2(DATA_DEPTH)-1:0] rd_offset;     // Words from the oldest frame's start
	eth_word_t                     rd_data;       // Valid the cycle after rd_en
	logic                          release_en;    // Frees the oldest frame
	logic [$clog2(DATA_DEPTH):0]   release_words;

	modport ctrl (output rd_en, rd_offset, release_en, release_words, input rd_data);
	modport target (input rd_en, rd_offset, release_en, release_words, output rd_data);
endinterface

`default_nettype wire

// ==== hw/frame_buf_pkg.sv ====
`default_nettype none

// Types used on the buffer and readout side
package frame_buf_pkg;

	// Byte position inside a buffered word
	// Lane 0 is the top octet and goes out first
	typedef logic [1:0] lane_idx_t;

	//////////////////////////////////////////////////
	// Pop controller states

	// IDLE       wait for a committed frame and tx_ready
	// LEN_TAKE   pop the length, fetch the first word
	// WORD_WAIT  first word comes back from the buffer
	// BYTE_OUT   step through the lanes, one byte per cycle
	// RELEASE    free the frame's words in the buffer
	typedef enum logic [2:0] {
		IDLE,
		LEN_TAKE,
		WORD_WAIT,
		BYTE_OUT,
		RELEASE
	} pop_state_t;

endpackage

`default_nettype wire

// ==== hw/eth_bus_pkg.sv ====
`default_nettype none

// Types of the Ethernet receive and transmit buses
package eth_bus_pkg;

	// One octet on the transmit side
	typedef logic [7:0] eth_byte_t;

	// One receive word
	// First byte of the frame sits in the top octet
	typedef logic [31:0] eth_word_t;

	// Valid bytes in a receive word, 1 to 4
	typedef logic [2:0] eth_lanes_t;

	// Frame length in bytes
	// 11 bits cover anything up to 2047 bytes
	typedef logic [10:0] frame_len_t;

endpackage

`default_nettype wire
